// File: include/bp_config.svh
/* Branch predictor parameters */

`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Instruction address width
`define BP_PC_W 32

// Global history length
// Also sets the PHT index width, 2**8 counters
`define BP_GHR_W 8

// Direct-mapped BTB rows, indexed by PC[5:2]
`define BP_BTB_ROWS 16

// BTB tag bits, taken right above the index
`define BP_BTB_TAG_W 10

// Outstanding branches, power of two
`define BP_OBQ_DEPTH 8

`endif

// File: src/bp_pkg.sv
/* Branch predictor types */

`include "bp_config.svh"

package bp_pkg;

	typedef logic [`BP_PC_W-1:0] pc_t; // Instruction address
	typedef logic [`BP_GHR_W-1:0] ghr_t; // Global history, bit 0 newest
	typedef logic [`BP_GHR_W-1:0] pht_idx_t; // PC xor history
	typedef logic [1:0] ctr_t; // 2-bit saturating counter

	// BTB row and tag fields of the PC
	typedef logic [$clog2(`BP_BTB_ROWS)-1:0] btb_idx_t;
	typedef logic [`BP_BTB_TAG_W-1:0] btb_tag_t;

	typedef logic [$clog2(`BP_OBQ_DEPTH)-1:0] obq_tag_t; // Queue slot

	// Outcome from execute
	typedef struct packed {
		pc_t      pc; // Branch PC
		pc_t      target; // Computed target
		logic     taken; // Actual direction
		logic     correct; // Prediction matched
		obq_tag_t tag; // Slot from prediction
	} resolve_t;

	// Prediction back to fetch
	typedef struct packed {
		pc_t      next_pc;
		logic     taken;
		obq_tag_t tag;
	} prediction_t;

endpackage

// File: src/branch_target_buffer.sv
/* Direct-mapped branch target buffer */

`include "bp_config.svh"

module branch_target_buffer import bp_pkg::*; (
	input  logic clock,
	input  logic rst_n,

	// Lookup from fetch
	input  pc_t  lookup_pc,
	output logic hit,
	output pc_t  target,

	// Update from taken resolves
	input  logic write_en,
	input  pc_t  write_pc,
	input  pc_t  write_target
);

	localparam int IDX_LO = 2; // Word aligned PCs
	localparam int TAG_LO = IDX_LO + $bits(btb_idx_t);

	logic [`BP_BTB_ROWS-1:0] valid_q; // One valid bit per row
	btb_tag_t tag_q [`BP_BTB_ROWS];
	pc_t target_q [`BP_BTB_ROWS];

	btb_idx_t lookup_idx;
	btb_tag_t lookup_tag;
	btb_idx_t write_idx;
	btb_tag_t write_tag;

	// Split PCs into row and tag
	assign lookup_idx = lookup_pc[TAG_LO-1:IDX_LO];
	assign lookup_tag = lookup_pc[TAG_LO+`BP_BTB_TAG_W-1:TAG_LO];
	assign write_idx  = write_pc[TAG_LO-1:IDX_LO];
	assign write_tag  = write_pc[TAG_LO+`BP_BTB_TAG_W-1:TAG_LO];

	// Combinational read, sees state before the edge
	assign hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
	assign target = target_q[lookup_idx]; // Only meaningful on hit

	// Valid bits are the only control state
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (write_en) begin
			valid_q[write_idx] <= 1'b1;
		end
	end

	// Tag and target payload
	// A write replaces whatever the row held
	always_ff @(posedge clock) begin
		if (write_en) begin
			tag_q[write_idx]    <= write_tag;
			target_q[write_idx] <= write_target;
		end
	end

endmodule

// File: src/gshare_predictor.sv
/* Gshare direction predictor */

`include "bp_config.svh"

module gshare_predictor import bp_pkg::*; (
	input  logic clock,
	input  logic rst_n,

	// Prediction side
	input  logic fetch_accept, // Prediction consumed, shift history
	input  pc_t  fetch_pc,
	output logic predict_taken,
	output ghr_t ghr, // History used for this prediction

	// Update side, one resolve per cycle
	input  logic update_en,
	input  logic mispredict, // Repair history from snapshot
	input  pc_t  update_pc,
	input  logic update_taken,
	input  ghr_t snapshot // History the branch was predicted with
);

	localparam int PHT_SIZE = 2 ** `BP_GHR_W;
	localparam ctr_t CTR_WNT = 2'b01; // Weakly not taken
	localparam ctr_t CTR_MAX = 2'b11;
	localparam ctr_t CTR_MIN = 2'b00;

	ctr_t pht_q [PHT_SIZE];
	ghr_t ghr_q;

	pht_idx_t pred_idx;
	pht_idx_t upd_idx;
	ctr_t upd_ctr;

	// Fold PC word bits with history
	assign pred_idx = fetch_pc[`BP_GHR_W+1:2] ^ ghr_q;
	assign upd_idx  = update_pc[`BP_GHR_W+1:2] ^ snapshot;

	assign predict_taken = pht_q[pred_idx][1]; // MSB of counter
	assign ghr           = ghr_q;
	assign upd_ctr       = pht_q[upd_idx];

	// Counter table
	// Reads above see the old value in an update cycle
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < PHT_SIZE; i++) begin
				pht_q[i] <= CTR_WNT;
			end
		end else if (update_en) begin
			if (update_taken) begin
				if (upd_ctr != CTR_MAX) begin
					pht_q[upd_idx] <= upd_ctr + 2'd1; // Count up, saturate at 3
				end
			end else begin
				if (upd_ctr != CTR_MIN) begin
					pht_q[upd_idx] <= upd_ctr - 2'd1; // Count down, saturate at 0
				end
			end
		end
	end

	// Speculative history
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ghr_q <= '0;
		end else if (mispredict) begin
			// Older history plus the real outcome
			ghr_q <= {snapshot[`BP_GHR_W-2:0], update_taken};
		end else if (fetch_accept) begin
			ghr_q <= {ghr_q[`BP_GHR_W-2:0], predict_taken}; // Shift in guess
		end
	end

endmodule

// File: src/branch_history_queue.sv
/* Outstanding branch queue */

`include "bp_config.svh"

module branch_history_queue import bp_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,

	// Tail side, from prediction
	input  logic     push,
	input  ghr_t     push_ghr, // History snapshot for the new branch
	output obq_tag_t push_tag, // Slot the push lands in
	output logic     full,

	// Head side, from resolve
	input  logic     pop,
	input  logic     flush, // Drop everything after the head
	output ghr_t     head_ghr,
	output obq_tag_t head_tag
);

	localparam int PTR_W = $bits(obq_tag_t);

	ghr_t snap_q [`BP_OBQ_DEPTH];

	// Pointers carry a wrap bit above the slot
	logic [PTR_W:0] head_q;
	logic [PTR_W:0] tail_q;
	logic [PTR_W:0] head_nxt;

	// Same slot, different lap
	assign full = (head_q[PTR_W] != tail_q[PTR_W])
		&& (head_q[PTR_W-1:0] == tail_q[PTR_W-1:0]);

	assign push_tag = tail_q[PTR_W-1:0];
	assign head_tag = head_q[PTR_W-1:0];
	assign head_ghr = snap_q[head_tag]; // Read before any pop
	assign head_nxt = pop ? head_q + 1'b1 : head_q;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
		end else if (flush) begin
			// Empty, next tag follows the popped head
			head_q <= head_nxt;
			tail_q <= head_nxt;
		end else begin
			head_q <= head_nxt;
			if (push) begin
				tail_q <= tail_q + 1'b1;
			end
		end
	end

	// Snapshot storage
	always_ff @(posedge clock) begin
		if (push && !flush) begin
			snap_q[push_tag] <= push_ghr;
		end
	end

endmodule

// File: src/branch_predictor.sv
/* Branch predictor top */

module branch_predictor import bp_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,

	// Fetch request, plain strobe
	input  logic        fetch_valid,
	input  pc_t         fetch_pc,

	// Resolve from execute, in program order
	input  logic        resolve_valid,
	input  resolve_t    resolve,

	// Prediction one cycle after fetch
	output logic        pred_valid,
	output prediction_t pred,
	output logic        obq_full // Fetches dropped while high
);

	logic fetch_accept;
	logic retire;
	logic mispredict;

	logic predict_taken;
	ghr_t ghr; // Current speculative history
	logic btb_hit;
	pc_t btb_target;

	ghr_t head_ghr;
	obq_tag_t push_tag;
	obq_tag_t obq_head_tag; // Checked against resolve tag

	assign retire       = resolve_valid && resolve.correct;
	assign mispredict   = resolve_valid && !resolve.correct;
	assign fetch_accept = fetch_valid && !obq_full && !mispredict; // Flush wins

	branch_target_buffer u_btb (
		.clock        (clock),
		.rst_n        (rst_n),
		.lookup_pc    (fetch_pc),
		.hit          (btb_hit),
		.target       (btb_target),
		.write_en     (resolve_valid && resolve.taken), // Only taken branches
		.write_pc     (resolve.pc),
		.write_target (resolve.target)
	);

	gshare_predictor u_gshare (
		.clock         (clock),
		.rst_n         (rst_n),
		.fetch_accept  (fetch_accept),
		.fetch_pc      (fetch_pc),
		.predict_taken (predict_taken),
		.ghr           (ghr),
		.update_en     (retire || mispredict),
		.mispredict    (mispredict),
		.update_pc     (resolve.pc),
		.update_taken  (resolve.taken),
		.snapshot      (head_ghr)
	);

	branch_history_queue u_obq (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (fetch_accept),
		.push_ghr (ghr),
		.push_tag (push_tag),
		.full     (obq_full),
		.pop      (retire || mispredict), // Resolved branch is the head
		.flush    (mispredict),
		.head_ghr (head_ghr),
		.head_tag (obq_head_tag)
	);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pred_valid <= 1'b0;
		end else begin
			pred_valid <= fetch_accept; // Single cycle pulse
		end
	end

	// Prediction payload
	always_ff @(posedge clock) begin
		if (fetch_accept) begin
			// Redirect needs both a taken guess and a known target
			pred.next_pc <= (predict_taken && btb_hit) ? btb_target : fetch_pc + pc_t'(4);
			pred.taken   <= predict_taken;
			pred.tag     <= push_tag;
		end
	end

endmodule

// File: verif/bp_clock_gen.sv
/* Testbench clock and reset */

module bp_clock_gen (
	output logic clock,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	// Held over two rising edges, released between edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

// File: verif/bp_asserts.sv
/* Predictor assertions */

module bp_asserts import bp_pkg::*; (
	input logic     clock,
	input logic     rst_n,
	input logic     fetch_valid,
	input logic     resolve_valid,
	input resolve_t resolve,
	input logic     pred_valid,
	input logic     obq_full,
	input logic     mispredict,
	input obq_tag_t head_tag
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // Failed assertions so far

	// Resolves arrive in order and always name the oldest branch
	a_resolve_at_head: assert property (@(posedge clock) disable iff (!rst_n)
		resolve_valid |-> resolve.tag == head_tag)
		else begin
			fail_count++;
			$error("Resolve tag %0d is not the queue head %0d", resolve.tag, head_tag);
		end

	// No prediction out of reset or without a fetch
	a_no_stray_pred: assert property (@(posedge clock)
		(!rst_n || !fetch_valid) |=> !pred_valid)
		else begin
			fail_count++;
			$error("pred_valid high without a fetch in the cycle before");
		end

	// Flush leaves the queue empty
	a_flush_not_full: assert property (@(posedge clock) disable iff (!rst_n)
		mispredict |=> !obq_full)
		else begin
			fail_count++;
			$error("Queue full right after a mispredict");
		end

	// A fetch into a full queue is dropped
	a_no_push_when_full: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_valid && obq_full |=> !pred_valid)
		else begin
			fail_count++;
			$error("Prediction given for a fetch while the queue was full");
		end

endmodule

// File: verif/tb_branch_predictor.sv
/* Branch predictor testbench */

`include "bp_config.svh"

module tb_branch_predictor import bp_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = `BP_OBQ_DEPTH;
	localparam int PHT_SIZE = 2 ** `BP_GHR_W;
	localparam int RESET_WAIT = 20; // Cycles
	localparam int DRAIN_WAIT = 4 * DEPTH;

	logic clock;
	logic rst_n;
	logic fetch_valid;
	pc_t fetch_pc;
	logic resolve_valid;
	resolve_t resolve;
	logic pred_valid;
	prediction_t pred;
	logic obq_full;

	logic [31:0] lfsr;
	pc_t pc_pool [32]; // Small pool so tables alias
	string phase;
	int value_errors;
	int timeout_errors;
	int coverage_errors;
	int checks;
	int drops; // Fetches seen while full
	int mispredicts;

	// Reference model state
	ctr_t m_pht [PHT_SIZE];
	ghr_t m_ghr;
	logic m_btb_valid [`BP_BTB_ROWS];
	btb_tag_t m_btb_tag [`BP_BTB_ROWS];
	pc_t m_btb_target [`BP_BTB_ROWS];
	ghr_t m_q_ghr [DEPTH];
	pc_t m_q_pc [DEPTH];
	logic m_q_pred [DEPTH]; // Predicted direction per slot
	int m_head;
	int m_tail;
	int m_count;
	logic exp_valid;
	prediction_t exp_pred;

	bp_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

	branch_predictor DUT (
		.clock         (clock),
		.rst_n         (rst_n),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.resolve_valid (resolve_valid),
		.resolve       (resolve),
		.pred_valid    (pred_valid),
		.pred          (pred),
		.obq_full      (obq_full)
	);

	bind branch_predictor bp_asserts u_asserts (
		.clock(clock), .rst_n(rst_n), .fetch_valid(fetch_valid),
		.resolve_valid(resolve_valid), .resolve(resolve), .pred_valid(pred_valid),
		.obq_full(obq_full), .mispredict(mispredict),
		.head_tag(obq_head_tag)
	);

	// Galois LFSR stepped once per bit drawn
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return r;
	endfunction

	// Outputs against the model state after the last edge
	task automatic check_outputs();
		checks++;
		if (obq_full !== (m_count == DEPTH))
			$display("[FAIL] %s obq_full: expected %0b, actual %0b", phase, m_count == DEPTH, obq_full);
		if (obq_full !== (m_count == DEPTH)) value_errors++;
		if (pred_valid !== exp_valid) begin
			value_errors++;
			$display("[FAIL] %s pred_valid: expected %0b, actual %0b", phase, exp_valid, pred_valid);
		end
		if (exp_valid && pred_valid === 1'b1) begin
			if (pred.taken !== exp_pred.taken) begin
				value_errors++;
				$display("[FAIL] %s taken: expected %0b, actual %0b", phase, exp_pred.taken, pred.taken);
			end
			if (pred.next_pc !== exp_pred.next_pc) begin
				value_errors++;
				$display("[FAIL] %s next_pc: expected %h, actual %h", phase, exp_pred.next_pc,
					pred.next_pc);
			end
			if (pred.tag !== exp_pred.tag) begin
				value_errors++;
				$display("[FAIL] %s tag: expected %0d, actual %0d", phase, exp_pred.tag, pred.tag);
			end
		end
	endtask

	// One clock edge of the predictor state
	task automatic model_step(input logic fv, input pc_t fpc, input logic rv, input resolve_t res);
		logic mis;
		logic accept;
		logic ptaken;
		ghr_t snap;
		pht_idx_t idx;
		btb_idx_t row;
		mis = rv && !res.correct;
		accept = fv && (m_count < DEPTH) && !mis; // Mispredict drops the fetch
		idx = fpc[9:2] ^ m_ghr;
		ptaken = m_pht[idx][1];
		row = fpc[5:2];
		exp_valid = accept;
		if (accept) begin
			exp_pred.taken = ptaken;
			exp_pred.tag = obq_tag_t'(m_tail);
			if (ptaken && m_btb_valid[row] && m_btb_tag[row] == fpc[15:6])
				exp_pred.next_pc = m_btb_target[row];
			else
				exp_pred.next_pc = fpc + 32'd4;
		end
		snap = m_q_ghr[m_head]; // Head history before any pop
		if (rv) begin
			idx = res.pc[9:2] ^ snap;
			if (res.taken && m_pht[idx] != 2'd3) m_pht[idx] = m_pht[idx] + 2'd1;
			if (!res.taken && m_pht[idx] != 2'd0) m_pht[idx] = m_pht[idx] - 2'd1;
			if (res.taken) begin
				row = res.pc[5:2];
				m_btb_valid[row] = 1'b1;
				m_btb_tag[row] = res.pc[15:6];
				m_btb_target[row] = res.target;
			end
		end
		if (accept) begin
			m_q_ghr[m_tail] = m_ghr; // Snapshot is the pre-shift history
			m_q_pc[m_tail] = fpc;
			m_q_pred[m_tail] = ptaken;
			m_tail = (m_tail + 1) % DEPTH;
			m_count++;
		end
		if (rv) begin
			m_head = (m_head + 1) % DEPTH;
			m_count--;
		end
		if (mis) begin
			m_tail = m_head; // Queue empties and tags restart after the popped head
			m_count = 0;
			m_ghr = {snap[`BP_GHR_W-2:0], res.taken};
		end else if (accept) begin
			m_ghr = {m_ghr[`BP_GHR_W-2:0], ptaken};
		end
	endtask

	// Check, drive at the falling edge, step the model
	task automatic run_cycle(input logic fv, input pc_t fpc, input logic rv, input resolve_t res);
		check_outputs();
		fetch_valid = fv;
		fetch_pc = fpc;
		resolve_valid = rv;
		resolve = res;
		if (fv && m_count == DEPTH) drops++;
		if (rv && !res.correct) mispredicts++;
		model_step(fv, fpc, rv, res);
		@(negedge clock);
	endtask

	// Thresholds are out of 8; hammer keeps one PC mostly taken
	task automatic random_cycle(input int fetch_thr, input int resolve_thr, input int flip_thr,
		input logic hammer);
		logic fv;
		logic rv;
		pc_t fpc;
		resolve_t res;
		logic dir;
		fv = rand_bits(3) < fetch_thr;
		fpc = hammer ? pc_pool[0] : pc_pool[rand_bits(5)];
		rv = 1'b0;
		res = '0;
		if (m_count > 0 && rand_bits(3) < resolve_thr) begin
			rv = 1'b1;
			dir = m_q_pred[m_head];
			res.pc = m_q_pc[m_head];
			res.tag = obq_tag_t'(m_head);
			res.target = rand_bits(30) << 2;
			if (hammer) res.taken = rand_bits(3) >= flip_thr;
			else res.taken = dir ^ (rand_bits(3) < flip_thr);
			res.correct = res.taken == dir;
		end
		run_cycle(fv, fpc, rv, res);
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < RESET_WAIT) begin
			@(posedge clock);
			n++;
		end
		if (rst_n !== 1'b1) begin
			timeout_errors++;
			$display("Reset was not released within %0d cycles", RESET_WAIT);
		end
		@(negedge clock);
	endtask

	// Retire everything still in flight as correct
	task automatic drain_queue();
		resolve_t res;
		int n;
		n = 0;
		while (m_count > 0 && n < DRAIN_WAIT) begin
			res = '0;
			res.pc = m_q_pc[m_head];
			res.tag = obq_tag_t'(m_head);
			res.taken = m_q_pred[m_head];
			res.target = m_q_pc[m_head] + 32'h40;
			res.correct = 1'b1;
			run_cycle(1'b0, '0, 1'b1, res);
			n++;
		end
		if (m_count > 0) begin
			timeout_errors++;
			$display("Branch queue did not drain, %0d branches left", m_count);
		end
		run_cycle(1'b0, '0, 1'b0, '0); // Last expected values
	endtask

	task automatic finish_run();
		$display("Errors: %0d value, %0d timeout, %0d assertion, %0d coverage in %0d checks",
			value_errors, timeout_errors, DUT.u_asserts.fail_count, coverage_errors, checks);
		if (value_errors == 0 && timeout_errors == 0 && coverage_errors == 0
			&& DUT.u_asserts.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	initial begin
		lfsr = 32'h3da;
		value_errors = 0;
		timeout_errors = 0;
		coverage_errors = 0;
		checks = 0;
		drops = 0;
		mispredicts = 0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		resolve_valid = 1'b0;
		resolve = '0;
		// Model reset state
		for (int i = 0; i < PHT_SIZE; i++) m_pht[i] = 2'b01; // Weakly not taken
		for (int i = 0; i < `BP_BTB_ROWS; i++) m_btb_valid[i] = 1'b0;
		m_ghr = '0;
		m_head = 0;
		m_tail = 0;
		m_count = 0;
		exp_valid = 1'b0;
		for (int i = 0; i < 32; i++) pc_pool[i] = rand_bits(30) << 2;
		wait_reset();
		if (timeout_errors == 0) begin
			phase = "reset";
			check_outputs();
			phase = "cold"; // Fetch only on unseen PCs
			repeat (6) random_cycle(8, 0, 0, 1'b0);
			phase = "random";
			repeat (2000) random_cycle(6, 4, 3, 1'b0);
			phase = "fill"; // Rare resolves so the queue runs full
			repeat (400) random_cycle(7, 1, 1, 1'b0);
			phase = "hammer";
			repeat (400) random_cycle(4, 4, 1, 1'b1);
			phase = "drain";
			drain_queue();
			if (drops == 0 || mispredicts == 0) begin
				coverage_errors++;
				$display("Queue never ran full or no branch was mispredicted");
			end
		end
		finish_run();
	end

endmodule

// File: branch_predictor.f
+incdir+include
src/bp_pkg.sv
src/branch_target_buffer.sv
src/gshare_predictor.sv
src/branch_history_queue.sv
src/branch_predictor.sv
verif/bp_clock_gen.sv
verif/bp_asserts.sv
verif/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/bp_pkg.sv
      - src/branch_target_buffer.sv
      - src/gshare_predictor.sv
      - src/branch_history_queue.sv
      - src/branch_predictor.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/bp_clock_gen.sv
      - verif/bp_asserts.sv
      - verif/tb_branch_predictor.sv
